//--- Makefile
TOP  := mont_array_tb
SRCS := $(filter-out +%,$(shell cat mont_array.f))

obj_dir/V$(TOP): mont_array.f hw/mont_config.svh $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mont_array.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- hw/mont_array.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module mont_array (
    input  logic                clk,
    input  logic                resetn,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  mont_pkg::reg_addr_t wb_adr,
    input  mont_pkg::bus_word_t wb_dat_w,
    output mont_pkg::bus_word_t wb_dat_r,
    output logic                wb_ack
);
    import mont_pkg::*;

    mont_job_if    host_job ();
    mont_job_if    eng_job [`MONT_ENGINES] ();
    mont_result_if eng_res [`MONT_ENGINES] ();

    logic     res_valid;
    operand_t res_value;
    tag_t     res_tag;
    logic     pop;

    mont_wb_regs regs_i (
        .clk       (clk),
        .resetn    (resetn),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .job       (host_job),
        .res_valid (res_valid),
        .res_value (res_value),
        .res_tag   (res_tag),
        .pop       (pop)
    );

    mont_dispatch dispatch_i (
        .clk    (clk),
        .resetn (resetn),
        .in     (host_job),
        .out    (eng_job)
    );

    for (genvar i = 0; i < `MONT_ENGINES; i++) begin : g_engine
        mont_engine engine_i (
            .clk    (clk),
            .resetn (resetn),
            .job    (eng_job[i]),
            .result (eng_res[i])
        );
    end

    mont_collect collect_i (
        .clk       (clk),
        .resetn    (resetn),
        .in        (eng_res),
        .res_valid (res_valid),
        .res_value (res_value),
        .res_tag   (res_tag),
        .pop       (pop)
    );

endmodule

//--- hw/mont_collect.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module mont_collect (
    input  logic               clk,
    input  logic               resetn,
    mont_result_if.sink        in [`MONT_ENGINES],
    output logic               res_valid,
    output mont_pkg::operand_t res_value,
    output mont_pkg::tag_t     res_tag,
    input  logic               pop
);
    import mont_pkg::*;

    localparam int N = `MONT_ENGINES;

    logic [N-1:0] eng_valid;
    operand_t     eng_value [N];
    tag_t         eng_tag [N];
    engine_idx_t  rr_ptr;
    engine_idx_t  grant_idx;
    logic         grant_found;
    logic         take;
    logic         hold_valid;
    operand_t     hold_value;
    tag_t         hold_tag;

    assign take = grant_found && !hold_valid;

    for (genvar i = 0; i < N; i++) begin : g_in
        assign eng_valid[i] = in[i].valid;
        assign eng_value[i] = in[i].value;
        assign eng_tag[i]   = in[i].tag;
        assign in[i].ready  = take && grant_idx == engine_idx_t'(i);
    end

    // Walk from the far end back to the pointer so the nearest valid engine wins
    always_comb begin
        int j;
        grant_found = 1'b0;
        grant_idx   = rr_ptr;
        for (int k = N - 1; k >= 0; k--) begin
            j = int'(rr_ptr) + k;
            if (j >= N) j = j - N;
            if (eng_valid[j]) begin
                grant_found = 1'b1;
                grant_idx   = engine_idx_t'(j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            hold_valid <= 1'b0;
            rr_ptr     <= '0;
        end else if (take) begin
            hold_valid <= 1'b1;
            rr_ptr     <= (int'(grant_idx) == N - 1) ? '0 : grant_idx + 1'b1;
        end else if (pop) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hold_value <= eng_value[grant_idx];
            hold_tag   <= eng_tag[grant_idx];
        end
    end

    assign res_valid = hold_valid;
    assign res_value = hold_value;
    assign res_tag   = hold_tag;

endmodule

//--- hw/mont_config.svh
`ifndef MONT_CONFIG_SVH
`define MONT_CONFIG_SVH

// Operand width in bits must be a multiple of the bus width
`define MONT_WIDTH 128

`define MONT_ENGINES 4

// Wishbone data width and job tag width
`define MONT_BUS_WIDTH 32
`define MONT_TAG_WIDTH 8

`endif

//--- hw/mont_dispatch.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module mont_dispatch (
    input  logic       clk,
    input  logic       resetn,
    mont_job_if.sink   in,
    mont_job_if.source out [`MONT_ENGINES]
);
    import mont_pkg::*;

    localparam int N = `MONT_ENGINES;

    logic        pend_valid;
    operand_t    pend_a;
    operand_t    pend_b;
    operand_t    pend_m;
    tag_t        pend_tag;
    logic [N-1:0] eng_ready;
    logic        sel_found;
    engine_idx_t sel_idx;

    assign in.ready = !pend_valid;

    for (genvar i = 0; i < N; i++) begin : g_out
        assign eng_ready[i]  = out[i].ready;
        assign out[i].valid  = pend_valid && sel_found && sel_idx == engine_idx_t'(i);
        assign out[i].a      = pend_a;
        assign out[i].b      = pend_b;
        assign out[i].m      = pend_m;
        assign out[i].tag    = pend_tag;
    end

    // Scan downward so the lowest idle engine is the one left selected
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (eng_ready[i]) begin
                sel_found = 1'b1;
                sel_idx   = engine_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend_valid <= 1'b0;
        end else if (in.valid && in.ready) begin
            pend_valid <= 1'b1;
        end else if (pend_valid && sel_found) begin
            pend_valid <= 1'b0;     // Handed to the selected engine this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            pend_a   <= in.a;
            pend_b   <= in.b;
            pend_m   <= in.m;
            pend_tag <= in.tag;
        end
    end

endmodule

//--- hw/mont_engine.sv
`timescale 1ns/1ps

module mont_engine (
    input  logic          clk,
    input  logic          resetn,
    mont_job_if.sink      job,
    mont_result_if.source result
);
    import mont_pkg::*;

    localparam int W  = $bits(operand_t);
    localparam int CW = $clog2(W + 1);

    typedef enum logic [2:0] {ST_IDLE, ST_RUN, ST_SUB, ST_OUT, ST_DONE} state_t;

    state_t        state;
    logic [CW-1:0] cnt;
    operand_t      a_q;
    operand_t      b_q;
    operand_t      m_q;
    operand_t      res_q;
    tag_t          tag_q;
    logic [W:0]    acc;     // Stays below 2M between steps
    logic [W+1:0]  sum_b;
    logic [W+1:0]  sum_m;

    assign sum_b = {1'b0, acc} + (a_q[0] ? {2'b00, b_q} : '0);
    assign sum_m = sum_b + (sum_b[0] ? {2'b00, m_q} : '0);

    assign job.ready    = state == ST_IDLE;
    assign result.valid = state == ST_DONE;
    assign result.value = res_q;
    assign result.tag   = tag_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (job.valid) begin
                        state <= ST_RUN;
                        cnt   <= '0;
                    end
                end
                ST_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(W - 1)) state <= ST_SUB;
                end
                ST_SUB:  state <= ST_OUT;
                ST_OUT:  state <= ST_DONE;
                ST_DONE: if (result.ready) state <= ST_IDLE; // Idle only once the result is taken
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job.valid && job.ready) begin
            a_q   <= job.a;
            b_q   <= job.b;
            m_q   <= job.m;
            tag_q <= job.tag;
            acc   <= '0;
        end else if (state == ST_RUN) begin
            a_q <= a_q >> 1;
            acc <= sum_m[W+1:1];
        end else if (state == ST_SUB && acc >= {1'b0, m_q}) begin
            acc <= acc - {1'b0, m_q};
        end
        if (state == ST_OUT) res_q <= acc[W-1:0];
    end

endmodule

//--- hw/mont_if.sv
`timescale 1ns/1ps

interface mont_job_if;
    import mont_pkg::*;

    logic     valid;
    logic     ready;
    operand_t a;
    operand_t b;
    operand_t m;
    tag_t     tag;

    modport source (output valid, a, b, m, tag, input ready);
    modport sink   (input valid, a, b, m, tag, output ready);
endinterface

interface mont_result_if;
    import mont_pkg::*;

    logic     valid;
    logic     ready;
    operand_t value;
    tag_t     tag;

    modport source (output valid, value, tag, input ready);
    modport sink   (input valid, value, tag, output ready);
endinterface

//--- hw/mont_pkg.sv
package mont_pkg;

`include "mont_config.svh"

    typedef logic [`MONT_WIDTH-1:0]     operand_t;
    typedef logic [`MONT_TAG_WIDTH-1:0] tag_t;
    typedef logic [`MONT_BUS_WIDTH-1:0] bus_word_t;
    typedef logic [5:0]                 reg_addr_t;

    // A single engine still gets a one-bit index
    typedef logic [$clog2(`MONT_ENGINES > 1 ? `MONT_ENGINES : 2)-1:0] engine_idx_t;

    localparam int OP_WORDS = `MONT_WIDTH / `MONT_BUS_WIDTH;

    // Operand blocks first, then control words, then the result block and pop
    localparam reg_addr_t REG_A_BASE   = reg_addr_t'(0);
    localparam reg_addr_t REG_B_BASE   = reg_addr_t'(OP_WORDS);
    localparam reg_addr_t REG_M_BASE   = reg_addr_t'(2 * OP_WORDS);
    localparam reg_addr_t REG_CMD      = reg_addr_t'(3 * OP_WORDS);
    localparam reg_addr_t REG_STATUS   = reg_addr_t'(3 * OP_WORDS + 1);
    localparam reg_addr_t REG_RES_TAG  = reg_addr_t'(3 * OP_WORDS + 2);
    localparam reg_addr_t REG_RES_BASE = reg_addr_t'(4 * OP_WORDS);
    localparam reg_addr_t REG_POP      = reg_addr_t'(5 * OP_WORDS);

endpackage

//--- hw/mont_wb_regs.sv
`timescale 1ns/1ps

module mont_wb_regs (
    input  logic                clk,
    input  logic                resetn,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  mont_pkg::reg_addr_t wb_adr,
    input  mont_pkg::bus_word_t wb_dat_w,
    output mont_pkg::bus_word_t wb_dat_r,
    output logic                wb_ack,
    mont_job_if.source          job,
    input  logic                res_valid,
    input  mont_pkg::operand_t  res_value,
    input  mont_pkg::tag_t      res_tag,
    output logic                pop
);
    import mont_pkg::*;

    localparam int BW = $bits(bus_word_t);
    localparam int TW = $bits(tag_t);

    operand_t a_q;
    operand_t b_q;
    operand_t m_q;
    tag_t     tag_q;
    logic     job_valid;
    logic     req;
    logic     wr_en;
    logic     is_cmd;
    logic     slot_busy;

    assign req       = wb_cyc && wb_stb && !wb_ack; // The acked cycle is not a new request
    assign wr_en     = req && wb_we;
    assign is_cmd    = wb_adr == REG_CMD;
    assign pop       = wr_en && wb_adr == REG_POP;
    assign slot_busy = job_valid || !job.ready;

    assign job.valid = job_valid;
    assign job.a     = a_q;
    assign job.b     = b_q;
    assign job.m     = m_q;
    assign job.tag   = tag_q;

    // A command write holds off its ack until the dispatcher takes the job
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_ack    <= 1'b0;
            job_valid <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (job_valid && job.ready) begin
                job_valid <= 1'b0;
                wb_ack    <= 1'b1;
            end else if (wr_en && is_cmd) begin
                job_valid <= 1'b1;
            end else if (req) begin
                wb_ack <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < OP_WORDS; i++) begin
            if (wr_en && wb_adr == REG_A_BASE + reg_addr_t'(i)) a_q[i*BW +: BW] <= wb_dat_w;
            if (wr_en && wb_adr == REG_B_BASE + reg_addr_t'(i)) b_q[i*BW +: BW] <= wb_dat_w;
            if (wr_en && wb_adr == REG_M_BASE + reg_addr_t'(i)) m_q[i*BW +: BW] <= wb_dat_w;
        end
        if (wr_en && is_cmd && !job_valid) tag_q <= wb_dat_w[TW-1:0];
    end

    always_comb begin
        wb_dat_r = '0;
        if (wb_adr == REG_STATUS) begin
            wb_dat_r = bus_word_t'({slot_busy, res_valid});
        end else if (wb_adr == REG_RES_TAG && res_valid) begin
            wb_dat_r = bus_word_t'(res_tag);
        end
        for (int i = 0; i < OP_WORDS; i++) begin
            if (res_valid && wb_adr == REG_RES_BASE + reg_addr_t'(i))
                wb_dat_r = res_value[i*BW +: BW];
        end
    end

endmodule

//--- mont_array.f
+incdir+hw
hw/mont_pkg.sv
hw/mont_if.sv
hw/mont_wb_regs.sv
hw/mont_dispatch.sv
hw/mont_engine.sv
hw/mont_collect.sv
hw/mont_array.sv
verification/tb_clock_gen.sv
verification/mont_array_tb.sv

//--- verification/mont_array_tb.sv
`timescale 1ns/1ps
`include "mont_config.svh"

module mont_array_tb;
    import mont_pkg::*;

    localparam int W        = `MONT_WIDTH;
    localparam int N        = `MONT_ENGINES;
    localparam int BW       = `MONT_BUS_WIDTH;
    localparam int ACK_WAIT = 2000;     // A command may stall behind busy engines
    localparam int POLLS    = 500;
    localparam int DRAIN    = 10;

    logic      clk;
    logic      resetn;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    reg_addr_t wb_adr;
    bus_word_t wb_dat_w;
    bus_word_t wb_dat_r;
    logic      wb_ack;

    logic [31:0] rng_state = 32'd96575;
    int          errors = 0;
    int          checks = 0;
    logic        aborted = 1'b0;
    string       cur_test = "none";
    operand_t    exp_val [tag_t];       // Expected value of every outstanding tag
    tag_t        got_tag [$];
    operand_t    got_val [$];

    tb_clock_gen clk_gen_i (.clk(clk), .resetn(resetn));

    mont_array dut_i (.*);

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic operand_t rand_operand();
        operand_t v;
        for (int i = 0; i < OP_WORDS; i++) v[i*BW +: BW] = next_rand();
        return v;
    endfunction

    function automatic operand_t rand_modulus();
        operand_t v;
        v = rand_operand();
        v[W-1] = 1'b1;
        v[0]   = 1'b1;
        return v;
    endfunction

    // Reduce the full product first, then divide by 2^W one bit at a time
    function automatic operand_t mont_ref(input operand_t a, input operand_t b,
                                          input operand_t m);
        logic [2*W-1:0] prod;
        logic [2*W-1:0] rem;
        logic [W:0]     t;
        prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        rem  = prod % {{W{1'b0}}, m};
        t    = rem[W:0];
        for (int i = 0; i < W; i++) begin
            if (t[0]) t = t + {1'b0, m};
            t = t >> 1;
        end
        return t[W-1:0];
    endfunction

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic stop_run(input string msg);
        errors++;
        aborted = 1'b1;
        $display("Timeout in test %s: %s", cur_test, msg);
        finish_run();
    endtask

    task automatic check_word(input string what, input bus_word_t expected,
                              input bus_word_t actual);
        if (aborted) return;
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic wb_xfer(input logic we, input reg_addr_t adr, input bus_word_t wdat,
                           output bus_word_t rdat);
        int cnt;
        cnt = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        @(negedge clk);
        while (!wb_ack && cnt < ACK_WAIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!wb_ack) begin
            stop_run($sformatf("no ack for word address %0d", adr));
        end else begin
            rdat = wb_dat_r;
            @(posedge clk);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end
    endtask

    task automatic wb_write(input reg_addr_t adr, input bus_word_t data);
        bus_word_t dummy;
        wb_xfer(1'b1, adr, data, dummy);
    endtask

    task automatic wb_read(input reg_addr_t adr, output bus_word_t data);
        wb_xfer(1'b0, adr, '0, data);
    endtask

    task automatic write_operand(input reg_addr_t base, input operand_t val);
        for (int i = 0; i < OP_WORDS; i++) wb_write(base + reg_addr_t'(i), val[i*BW +: BW]);
    endtask

    task automatic send_cmd(input operand_t a, input operand_t b, input operand_t m,
                            input tag_t tag);
        exp_val[tag] = mont_ref(a, b, m);
        wb_write(REG_CMD, bus_word_t'(tag));
    endtask

    task automatic issue_job(input operand_t a, input operand_t b, input operand_t m,
                             input tag_t tag);
        write_operand(REG_A_BASE, a);
        write_operand(REG_B_BASE, b);
        write_operand(REG_M_BASE, m);
        send_cmd(a, b, m, tag);
    endtask

    task automatic wait_reset();
        int cnt;
        cnt = 0;
        while (!resetn && cnt < 100) begin
            @(negedge clk);
            cnt++;
        end
        if (!resetn) stop_run("reset was never released");
    endtask

    task automatic wait_result();
        bus_word_t st;
        int        polls;
        polls = 0;
        wb_read(REG_STATUS, st);
        while (!st[0] && polls < POLLS) begin
            wb_read(REG_STATUS, st);
            polls++;
        end
        if (!st[0]) stop_run("result valid never set");
    endtask

    // Read the held result, release it and queue it for the checker
    task automatic collect_result();
        bus_word_t w;
        tag_t      t;
        operand_t  v;
        wb_read(REG_RES_TAG, w);
        t = tag_t'(w);
        for (int i = 0; i < OP_WORDS; i++) begin
            wb_read(REG_RES_BASE + reg_addr_t'(i), w);
            v[i*BW +: BW] = w;
        end
        wb_write(REG_POP, '0);
        got_tag.push_back(t);
        got_val.push_back(v);
    endtask

    task automatic expect_all_returned();
        int cnt;
        cnt = 0;
        while (got_tag.size() > 0 && cnt < DRAIN) begin
            @(negedge clk);
            cnt++;
        end
        if (got_tag.size() > 0) stop_run("collected results were never checked");
        if (aborted) return;
        checks++;
        assert (exp_val.num() == 0) else begin
            errors++;
            $display("Test %s left %0d tags without a result", cur_test, exp_val.num());
        end
    endtask

    always @(negedge clk) begin : compare_results
        tag_t     t;
        operand_t v;
        while (got_tag.size() > 0) begin
            t = got_tag.pop_front();
            v = got_val.pop_front();
            checks++;
            assert (exp_val.exists(t)) else begin
                errors++;
                $display("Test %s returned tag %h that was not outstanding", cur_test, t);
            end
            if (exp_val.exists(t)) begin
                checks++;
                assert (v == exp_val[t]) else begin
                    errors++;
                    $display("Error %s tag %h: expected %h, actual %h",
                             cur_test, t, exp_val[t], v);
                end
                exp_val.delete(t);
            end
        end
    end

    initial begin
        bus_word_t st;
        operand_t  a;
        operand_t  b;
        operand_t  m;
        int        got;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wait_reset();

        cur_test = "reset_state";
        wb_read(REG_STATUS, st);
        check_word("status", '0, st);
        wb_read(REG_RES_TAG, st);
        check_word("result tag", '0, st);
        for (int i = 0; i < OP_WORDS; i++) begin
            wb_read(REG_RES_BASE + reg_addr_t'(i), st);
            check_word("result word", '0, st);
        end

        cur_test = "single_job";
        m = rand_modulus();
        a = rand_operand() % m;
        b = rand_operand() % m;
        issue_job(a, b, m, 8'h11);
        wait_result();
        collect_result();
        wb_read(REG_STATUS, st);
        check_word("status bit 0 after pop", '0, bus_word_t'(st[0]));
        expect_all_returned();

        cur_test = "edge_operands";
        m = rand_modulus();
        issue_job('0, operand_t'(1), m, 8'h21);
        wait_result();
        collect_result();
        issue_job(m - 1'b1, m - 1'b1, m, 8'h22);
        wait_result();
        collect_result();
        expect_all_returned();

        cur_test = "back_to_back";
        for (int i = 0; i < N; i++) begin
            m = rand_modulus();
            a = rand_operand() % m;
            b = rand_operand() % m;
            issue_job(a, b, m, tag_t'(8'h40 + i));
        end
        for (int i = 0; i < N; i++) begin
            wait_result();
            collect_result();
        end
        expect_all_returned();

        // Only A changes per job, so commands arrive faster than the engines finish
        cur_test = "backpressure";
        m = rand_modulus();
        b = rand_operand() % m;
        write_operand(REG_B_BASE, b);
        write_operand(REG_M_BASE, m);
        got = 0;
        for (int i = 0; i < 3 * N; i++) begin
            a = rand_operand() % m;
            write_operand(REG_A_BASE, a);
            send_cmd(a, b, m, tag_t'(8'h80 + i));
            wb_read(REG_STATUS, st);
            while (st[0] && got < 3 * N) begin
                collect_result();
                got++;
                wb_read(REG_STATUS, st);
            end
        end
        while (got < 3 * N) begin
            wait_result();
            collect_result();
            got++;
        end
        expect_all_returned();

        cur_test = "pop_when_empty";
        wb_write(REG_POP, '0);
        wb_read(REG_STATUS, st);
        check_word("status bit 0 after empty pop", '0, bus_word_t'(st[0]));
        m = rand_modulus();
        a = rand_operand() % m;
        b = rand_operand() % m;
        issue_job(a, b, m, 8'hC0);
        wait_result();
        collect_result();
        expect_all_returned();

        finish_run();
    end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic resetn
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // The synchronous reset is released on a rising edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end
endmodule
